// File: common/ifu_params.svh
`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define IFU_ADDR_W 32
`define IFU_DATA_W 32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L1I geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define L1I_SET_BITS  2 // Four sets.
`define L1I_WORD_BITS 1 // Two words per line.
`define L1I_SETS      (1 << `L1I_SET_BITS)
`define L1I_WORDS     (1 << `L1I_WORD_BITS)
`define L1I_TAG_W     (`IFU_ADDR_W - `L1I_SET_BITS - `L1I_WORD_BITS - 2)

// Reset vector and fence.i encoding.
`define IFU_PC_INIT      32'h8000_0000
`define IFU_INST_FENCE_I 32'h0000_100f

`endif

// File: common/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // RV32 major opcodes seen by fetch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [6:0] {
    OP_JAL      = 7'b1101111,
    OP_JALR     = 7'b1100111,
    OP_BRANCH   = 7'b1100011,
    OP_SYSTEM   = 7'b1110011,
    OP_LOAD     = 7'b0000011,
    OP_MISC_MEM = 7'b0001111, // fence and fence.i.
    OP_OTHER    = 7'b0010011  // Plain ALU, op-imm.
  } ifu_opcode_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // L1I refill states
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [2:0] {
    L1I_IDLE   = 3'd0,
    L1I_REQ_LO = 3'd1,
    L1I_GAP    = 3'd2,
    L1I_REQ_HI = 3'd3,
    L1I_DONE   = 3'd4
  } l1i_state_e;

  // Fetch controller hazard states.
  typedef enum logic [1:0] {
    FETCH_RUN         = 2'd0,
    FETCH_WAIT_BRANCH = 2'd1,
    FETCH_WAIT_LOAD   = 2'd2
  } fetch_state_e;

endpackage

`default_nettype wire

// File: l1i_cache/l1i_cache.sv
`timescale 1ns/10ps
`default_nettype none

`include "ifu_params.svh"

module l1i_cache
  import ifu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`IFU_ADDR_W-1:0] fetch_pc_i,
  input  logic                   flush_i,
  input  logic [`IFU_DATA_W-1:0] ifu_rdata_i,
  input  logic                   ifu_rvalid_i,
  output logic                   hit_o,
  output logic [`IFU_DATA_W-1:0] line_word_o,
  output logic                   fill_word_valid_o,
  output logic [`IFU_DATA_W-1:0] fill_word_o,
  output logic [`IFU_ADDR_W-1:0] ifu_araddr_o,
  output logic                   ifu_arvalid_o
);

  localparam int SET_LSB = 2 + `L1I_WORD_BITS;
  localparam int TAG_LSB = SET_LSB + `L1I_SET_BITS;
  localparam int LINE_W  = `IFU_ADDR_W - SET_LSB; // Tag and set.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arrays
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic [`L1I_SETS-1:0]   valid_q;
  logic [`L1I_TAG_W-1:0]  tag_q  [`L1I_SETS];
  logic [`IFU_DATA_W-1:0] data_q [`L1I_SETS][`L1I_WORDS];

  l1i_state_e state_q;
  logic [LINE_W-1:0] miss_line_q; // Line under refill.

  logic [`L1I_TAG_W-1:0]    pc_tag;
  logic [`L1I_SET_BITS-1:0] pc_set;
  logic [`L1I_WORD_BITS-1:0] pc_word;
  logic [LINE_W-1:0]        pc_line;

  logic [`L1I_TAG_W-1:0]     miss_tag;
  logic [`L1I_SET_BITS-1:0]  miss_set;
  logic [LINE_W-1:0]         req_line;
  logic [`L1I_WORD_BITS-1:0] req_word;
  logic                      lookup;

  assign pc_tag  = fetch_pc_i[`IFU_ADDR_W-1:TAG_LSB];
  assign pc_set  = fetch_pc_i[TAG_LSB-1:SET_LSB];
  assign pc_word = fetch_pc_i[SET_LSB-1:2];
  assign pc_line = fetch_pc_i[`IFU_ADDR_W-1:SET_LSB];

  assign miss_tag = miss_line_q[LINE_W-1:`L1I_SET_BITS];
  assign miss_set = miss_line_q[`L1I_SET_BITS-1:0];

  // Lookup is blocked while a refill is in flight.
  assign lookup = (state_q == L1I_IDLE) || (state_q == L1I_DONE);
  assign hit_o  = lookup && valid_q[pc_set] && (tag_q[pc_set] == pc_tag);

  assign line_word_o = data_q[pc_set][pc_word];

  // High word bypass, only for the line the PC still points at.
  assign fill_word_valid_o = (state_q == L1I_REQ_HI) && ifu_rvalid_i && (miss_line_q == pc_line);
  assign fill_word_o       = ifu_rdata_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus request
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign req_line = (state_q == L1I_IDLE) ? pc_line : miss_line_q;
  assign req_word = `L1I_WORD_BITS'(state_q == L1I_REQ_HI);

  assign ifu_araddr_o  = {req_line, req_word, 2'b00};
  assign ifu_arvalid_o = ((state_q == L1I_IDLE) && !hit_o) ||
                         (state_q == L1I_REQ_LO) || (state_q == L1I_REQ_HI);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Refill FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= L1I_IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        L1I_IDLE: begin
          if (!hit_o) begin
            state_q <= L1I_REQ_LO;
          end
        end
        L1I_REQ_LO: begin
          if (ifu_rvalid_i) begin
            state_q           <= L1I_GAP;
            valid_q[miss_set] <= 1'b0; // Old line is being overwritten.
          end
        end
        L1I_GAP: state_q <= L1I_REQ_HI;
        L1I_REQ_HI: begin
          if (ifu_rvalid_i) begin
            state_q           <= L1I_DONE;
            valid_q[miss_set] <= 1'b1;
          end
        end
        L1I_DONE: state_q <= L1I_IDLE;
        default:  state_q <= L1I_IDLE;
      endcase
      if (flush_i) begin
        valid_q <= '0; // fence.i wins over a fill.
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == L1I_IDLE) && !hit_o) begin
      miss_line_q <= pc_line;
    end
    if ((state_q == L1I_REQ_LO) && ifu_rvalid_i) begin
      data_q[miss_set][0] <= ifu_rdata_i;
    end
    if ((state_q == L1I_REQ_HI) && ifu_rvalid_i) begin
      data_q[miss_set][1] <= ifu_rdata_i;
      tag_q[miss_set]     <= miss_tag;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    ifu_arvalid_o && !ifu_rvalid_i |=> ifu_arvalid_o && $stable(ifu_araddr_o));

  // Gap or done cycle after every response.
  a_no_req_idle_phase: assert property (@(posedge clk) disable iff (rst)
    ifu_rvalid_i |=> !ifu_arvalid_o);

endmodule

`default_nettype wire

// File: design/ifu_fetch_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "ifu_params.svh"

module ifu_fetch_ctrl
  import ifu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   hit_i,
  input  logic [`IFU_DATA_W-1:0] line_word_i,
  input  logic                   fill_word_valid_i,
  input  logic [`IFU_DATA_W-1:0] fill_word_i,
  input  logic [`IFU_ADDR_W-1:0] npc_i,
  input  logic                   pc_change_i,
  input  logic                   pc_retire_i,
  input  logic                   prev_valid_i,
  input  logic                   next_ready_i,
  output logic [`IFU_ADDR_W-1:0] fetch_pc_o,
  output logic                   flush_o,
  output logic [`IFU_DATA_W-1:0] inst_o,
  output logic [`IFU_ADDR_W-1:0] pc_o,
  output logic                   valid_o,
  output logic                   ready_o,
  output logic                   bad_speculation_o
);

  fetch_state_e           state_q;
  logic [`IFU_ADDR_W-1:0] pc_q;
  logic [`IFU_ADDR_W-1:0] btb_q;
  logic                   btb_valid_q;
  logic [`IFU_ADDR_W-1:0] spec_target_q;
  logic                   spec_q;

  ifu_opcode_e opcode;
  logic        is_branch;
  logic        is_load;
  logic        is_fence_i;
  logic        accept;
  logic        resolve;
  logic        spec_match;
  logic        redirect;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Delivery toward decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // High word of a refill comes straight off the bus.
  assign inst_o  = (fill_word_valid_i && pc_q[2]) ? fill_word_i : line_word_i;
  assign pc_o    = pc_q;
  assign valid_o = (state_q == FETCH_RUN) && (hit_i || fill_word_valid_i);
  assign ready_o = !valid_o;
  assign accept  = valid_o && next_ready_i;

  assign fetch_pc_o = pc_q;

  // Opcode classes.
  assign opcode = ifu_opcode_e'(inst_o[6:0]);

  always_comb begin
    is_branch  = 1'b0;
    is_load    = 1'b0;
    is_fence_i = 1'b0;
    case (opcode)
      OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM: is_branch = 1'b1;
      OP_LOAD:     is_load = 1'b1;
      OP_MISC_MEM: is_fence_i = (inst_o == `IFU_INST_FENCE_I);
      default: ;
    endcase
  end

  assign flush_o = accept && is_fence_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Resolution and speculation
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign resolve    = prev_valid_i && (pc_change_i || pc_retire_i);
  assign spec_match = spec_q && (npc_i == spec_target_q);
  assign redirect   = resolve && !spec_match; // Bad speculation included.

  assign bad_speculation_o = resolve && spec_q && (npc_i != spec_target_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= `IFU_PC_INIT;
      state_q     <= FETCH_RUN;
      btb_valid_q <= 1'b0;
      spec_q      <= 1'b0;
    end else begin
      if (prev_valid_i && pc_change_i) begin
        btb_valid_q <= 1'b1;
      end
      if (redirect) begin
        pc_q    <= npc_i;
        state_q <= FETCH_RUN;
        spec_q  <= 1'b0;
      end else begin
        if (resolve) begin
          spec_q <= 1'b0; // Guess was right.
        end
        if (accept) begin
          if (is_load) begin
            state_q <= FETCH_WAIT_LOAD;
          end else if (is_branch) begin
            if (btb_valid_q && !spec_q) begin
              pc_q   <= btb_q;
              spec_q <= 1'b1;
            end else begin
              state_q <= FETCH_WAIT_BRANCH;
            end
          end else begin
            pc_q <= pc_q + 4;
          end
        end
      end
    end
  end

  // Target storage.
  always_ff @(posedge clk) begin
    if (prev_valid_i && pc_change_i) begin
      btb_q <= npc_i;
    end
    if (!redirect && accept && is_branch && btb_valid_q && !spec_q) begin
      spec_target_q <= btb_q;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Held offer across the refill done cycle as well.
  a_hold_offer: assert property (@(posedge clk) disable iff (rst)
    valid_o && !next_ready_i && !resolve
    |=> valid_o && $stable(inst_o) && $stable(pc_o));

endmodule

`default_nettype wire

// File: design/ifu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "ifu_params.svh"

module ifu_top (
  input  logic                   clk,
  input  logic                   rst,
  // Instruction memory read bus.
  output logic [`IFU_ADDR_W-1:0] ifu_araddr_o,
  output logic                   ifu_arvalid_o,
  input  logic [`IFU_DATA_W-1:0] ifu_rdata_i,
  input  logic                   ifu_rvalid_i,
  // Resolution from writeback.
  input  logic [`IFU_ADDR_W-1:0] npc_i,
  input  logic                   pc_change_i,
  input  logic                   pc_retire_i,
  input  logic                   prev_valid_i,
  // Toward decode.
  input  logic                   next_ready_i,
  output logic [`IFU_DATA_W-1:0] inst_o,
  output logic [`IFU_ADDR_W-1:0] pc_o,
  output logic                   valid_o,
  output logic                   ready_o,
  output logic                   bad_speculation_o
);

  logic [`IFU_ADDR_W-1:0] fetch_pc;
  logic                   flush;
  logic                   hit;
  logic [`IFU_DATA_W-1:0] line_word;
  logic                   fill_word_valid;
  logic [`IFU_DATA_W-1:0] fill_word;

  ifu_fetch_ctrl i_ifu_fetch_ctrl (
    .clk               (clk),
    .rst               (rst),
    .hit_i             (hit),
    .line_word_i       (line_word),
    .fill_word_valid_i (fill_word_valid),
    .fill_word_i       (fill_word),
    .npc_i             (npc_i),
    .pc_change_i       (pc_change_i),
    .pc_retire_i       (pc_retire_i),
    .prev_valid_i      (prev_valid_i),
    .next_ready_i      (next_ready_i),
    .fetch_pc_o        (fetch_pc),
    .flush_o           (flush),
    .inst_o            (inst_o),
    .pc_o              (pc_o),
    .valid_o           (valid_o),
    .ready_o           (ready_o),
    .bad_speculation_o (bad_speculation_o)
  );

  l1i_cache i_l1i_cache (
    .clk               (clk),
    .rst               (rst),
    .fetch_pc_i        (fetch_pc),
    .flush_i           (flush),
    .ifu_rdata_i       (ifu_rdata_i),
    .ifu_rvalid_i      (ifu_rvalid_i),
    .hit_o             (hit),
    .line_word_o       (line_word),
    .fill_word_valid_o (fill_word_valid),
    .fill_word_o       (fill_word),
    .ifu_araddr_o      (ifu_araddr_o),
    .ifu_arvalid_o     (ifu_arvalid_o)
  );

endmodule

`default_nettype wire

// File: verif/tb_ifu.sv
`timescale 1ns/10ps
`default_nettype none

`include "ifu_params.svh"

module tb_ifu
  import ifu_pkg::*;
();

  localparam int          TIMEOUT_CYCLES = 4000; // Six tests, each well under 600 cycles.
  localparam int          MEM_WORDS      = 64;
  localparam logic [31:0] INST_LOAD      = 32'h0003_2283; // lw x5, 0(x6).
  localparam logic [31:0] INST_JAL       = 32'h0100_006f;
  localparam logic [31:0] INST_BEQ       = 32'h0000_0063;
  localparam logic [31:0] INST_NEW0      = 32'h00a0_0513;
  localparam logic [31:0] INST_NEW1      = 32'h0140_0593;
  localparam logic [31:0] TARGET_A       = `IFU_PC_INIT + 32'h40; // Set 0, other tag.
  localparam logic [31:0] TARGET_B       = `IFU_PC_INIT + 32'h88;

  logic                   clk;
  logic                   rst;
  logic [`IFU_ADDR_W-1:0] ifu_araddr_o;
  logic                   ifu_arvalid_o;
  logic [`IFU_DATA_W-1:0] ifu_rdata_i;
  logic                   ifu_rvalid_i;
  logic [`IFU_ADDR_W-1:0] npc_i;
  logic                   pc_change_i;
  logic                   pc_retire_i;
  logic                   prev_valid_i;
  logic                   next_ready_i;
  logic [`IFU_DATA_W-1:0] inst_o;
  logic [`IFU_ADDR_W-1:0] pc_o;
  logic                   valid_o;
  logic                   ready_o;
  logic                   bad_speculation_o;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] rng_state;
  logic        mem_busy;
  int          mem_wait;
  logic [31:0] mem_addr;
  logic [31:0] btb_model;
  int          bus_reads;
  int          error_count;
  int          tests_passed;
  int          tests_failed;
  int          cycle_count;

  ifu_top i_ifu_top (
    .clk               (clk),
    .rst               (rst),
    .ifu_araddr_o      (ifu_araddr_o),
    .ifu_arvalid_o     (ifu_arvalid_o),
    .ifu_rdata_i       (ifu_rdata_i),
    .ifu_rvalid_i      (ifu_rvalid_i),
    .npc_i             (npc_i),
    .pc_change_i       (pc_change_i),
    .pc_retire_i       (pc_retire_i),
    .prev_valid_i      (prev_valid_i),
    .next_ready_i      (next_ready_i),
    .inst_o            (inst_o),
    .pc_o              (pc_o),
    .valid_o           (valid_o),
    .ready_o           (ready_o),
    .bad_speculation_o (bad_speculation_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Memory model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Plain op-imm word, upper bits hashed from the address.
  function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
    logic [31:0] h;
    h = (addr ^ (addr >> 16)) * 32'h045d_9f3b;
    return {h[31:7], OP_OTHER};
  endfunction

  function automatic logic [31:0] mem_read(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - `IFU_PC_INIT;
    if (offset < 4 * MEM_WORDS) begin
      return mem[offset[31:2]];
    end
    return fill_pattern(addr);
  endfunction

  task automatic mem_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] offset;
    offset = addr - `IFU_PC_INIT;
    mem[offset[31:2]] = data;
  endtask

  task automatic load_fill();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_pattern(`IFU_PC_INIT + 4 * i);
    end
  endtask

  // One read in flight, answered 1 to 4 cycles later.
  always @(negedge clk) begin
    if (rst) begin
      ifu_rvalid_i = 1'b0;
      mem_busy     = 1'b0;
    end else if (ifu_rvalid_i) begin
      ifu_rvalid_i = 1'b0;
    end else if (mem_busy) begin
      if (mem_wait <= 1) begin
        ifu_rdata_i  = mem_read(mem_addr);
        ifu_rvalid_i = 1'b1;
        mem_busy     = 1'b0;
      end else begin
        mem_wait--;
      end
    end else if (ifu_arvalid_o) begin
      mem_busy  = 1'b1;
      mem_addr  = ifu_araddr_o;
      rng_state = xorshift32(rng_state);
      mem_wait  = 1 + int'(rng_state % 4);
    end
  end

  always @(posedge clk) begin
    if (!rst && ifu_arvalid_o && ifu_rvalid_i) begin
      bus_reads <= bus_reads + 1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Drivers and decode model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic apply_reset();
    rst          = 1'b1;
    next_ready_i = 1'b0;
    prev_valid_i = 1'b0;
    pc_change_i  = 1'b0;
    pc_retire_i  = 1'b0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
  endtask

  // Waits for an offer, then accepts it one cycle later.
  task automatic take_inst(input logic change_en, input logic [31:0] change_npc,
                           output logic [31:0] inst, output logic [31:0] pc);
    @(posedge clk);
    while (!valid_o) @(posedge clk);
    @(negedge clk);
    next_ready_i = 1'b1;
    if (change_en) begin
      prev_valid_i = 1'b1;
      pc_change_i  = 1'b1;
      npc_i        = change_npc;
      btb_model    = change_npc;
    end
    @(posedge clk);
    if (!valid_o) begin
      $display("Offer withdrawn under back-pressure at %0t", $time);
      error_count++;
    end
    if (ready_o !== ~valid_o) begin
      $display("MISMATCH at %0t: ready_o %b with valid_o %b", $time, ready_o, valid_o);
      error_count++;
    end
    inst = inst_o;
    pc   = pc_o;
    @(negedge clk);
    next_ready_i = 1'b0;
    prev_valid_i = 1'b0;
    pc_change_i  = 1'b0;
  endtask

  task automatic resolve_npc(input logic change, input logic [31:0] npc, input logic exp_bad);
    prev_valid_i = 1'b1;
    pc_change_i  = change;
    pc_retire_i  = !change;
    npc_i        = npc;
    if (change) begin
      btb_model = npc;
    end
    @(posedge clk);
    if (bad_speculation_o !== exp_bad) begin
      $display("MISMATCH at %0t: bad_speculation_o %b, expected %b", $time,
               bad_speculation_o, exp_bad);
      error_count++;
    end
    @(negedge clk);
    prev_valid_i = 1'b0;
    pc_change_i  = 1'b0;
    pc_retire_i  = 1'b0;
  endtask

  task automatic expect_stall(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      if (valid_o !== 1'b0) begin
        $display("MISMATCH at %0t: valid_o high during stall, pc_o %h", $time, pc_o);
        error_count++;
      end
      if (ready_o !== 1'b1) begin
        $display("MISMATCH at %0t: ready_o low during stall", $time);
        error_count++;
      end
    end
    @(negedge clk);
  endtask

  task automatic check_fetch(input logic [31:0] inst, input logic [31:0] pc,
                             input logic [31:0] exp_pc);
    if (pc !== exp_pc) begin
      $display("MISMATCH at %0t: pc_o %h, expected %h", $time, pc, exp_pc);
      error_count++;
    end
    if (inst !== mem_read(exp_pc)) begin
      $display("MISMATCH at %0t: inst_o %h at %h, expected %h", $time, inst, exp_pc,
               mem_read(exp_pc));
      error_count++;
    end
  endtask

  task automatic check_reads(input int got, input int exp);
    if (got != exp) begin
      $display("MISMATCH at %0t: %0d bus reads, expected %0d", $time, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    if (error_count == start_errors) begin
      $display("PASS %s", name);
      tests_passed++;
    end else begin
      $display("FAIL %s", name);
      tests_failed++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic sequential_fetch();
    int          start_errors;
    int          start_reads;
    logic [31:0] inst;
    logic [31:0] pc;
    start_errors = error_count;
    load_fill();
    apply_reset();
    start_reads = bus_reads;
    for (int i = 0; i < 8; i++) begin
      take_inst(i == 7, `IFU_PC_INIT, inst, pc); // Last one redirects back home.
      check_fetch(inst, pc, `IFU_PC_INIT + 4 * i);
    end
    check_reads(bus_reads - start_reads, 8);
    report_test("sequential_fetch", start_errors);
  endtask

  task automatic cache_reuse();
    int          start_errors;
    int          start_reads;
    logic [31:0] inst;
    logic [31:0] pc;
    start_errors = error_count;
    start_reads  = bus_reads;
    for (int i = 0; i < 8; i++) begin
      take_inst(1'b0, '0, inst, pc);
      check_fetch(inst, pc, `IFU_PC_INIT + 4 * i);
    end
    check_reads(bus_reads - start_reads, 0);
    report_test("cache_reuse", start_errors);
  endtask

  task automatic load_stall();
    int          start_errors;
    logic [31:0] inst;
    logic [31:0] pc;
    start_errors = error_count;
    load_fill();
    mem_write(`IFU_PC_INIT + 4, INST_LOAD);
    apply_reset();
    take_inst(1'b0, '0, inst, pc);
    check_fetch(inst, pc, `IFU_PC_INIT);
    take_inst(1'b0, '0, inst, pc);
    check_fetch(inst, pc, `IFU_PC_INIT + 4);
    expect_stall(10);
    resolve_npc(1'b0, `IFU_PC_INIT + 8, 1'b0);
    take_inst(1'b0, '0, inst, pc);
    check_fetch(inst, pc, `IFU_PC_INIT + 8);
    report_test("load_stall", start_errors);
  endtask

  task automatic branch_no_predict();
    int          start_errors;
    logic [31:0] inst;
    logic [31:0] pc;
    start_errors = error_count;
    load_fill();
    mem_write(`IFU_PC_INIT + 4, INST_JAL);
    mem_write(TARGET_A + 4, INST_BEQ);
    apply_reset(); // BTB empty.
    take_inst(1'b0, '0, inst, pc);
    check_fetch(inst, pc, `IFU_PC_INIT);
    take_inst(1'b0, '0, inst, pc);
    check_fetch(inst, pc, `IFU_PC_INIT + 4);
    expect_stall(5);
    resolve_npc(1'b1, TARGET_A, 1'b0);
    take_inst(1'b0, '0, inst, pc);
    check_fetch(inst, pc, TARGET_A);
    report_test("branch_no_predict", start_errors);
  endtask

  task automatic speculation();
    int          start_errors;
    logic [31:0] inst;
    logic [31:0] pc;
    start_errors = error_count;
    take_inst(1'b0, '0, inst, pc);
    check_fetch(inst, pc, TARGET_A + 4);
    take_inst(1'b0, '0, inst, pc);
    check_fetch(inst, pc, btb_model);
    resolve_npc(1'b1, btb_model, 1'b0); // Correct guess.
    take_inst(1'b0, '0, inst, pc);
    check_fetch(inst, pc, TARGET_A + 4);
    take_inst(1'b0, '0, inst, pc);
    check_fetch(inst, pc, btb_model);
    resolve_npc(1'b1, TARGET_B, 1'b1);
    take_inst(1'b0, '0, inst, pc);
    check_fetch(inst, pc, TARGET_B);
    report_test("speculation", start_errors);
  endtask

  task automatic fence_invalidate();
    int          start_errors;
    int          start_reads;
    logic [31:0] inst;
    logic [31:0] pc;
    start_errors = error_count;
    load_fill();
    mem_write(`IFU_PC_INIT + 8, `IFU_INST_FENCE_I);
    apply_reset();
    take_inst(1'b0, '0, inst, pc);
    check_fetch(inst, pc, `IFU_PC_INIT);
    take_inst(1'b0, '0, inst, pc);
    check_fetch(inst, pc, `IFU_PC_INIT + 4);
    mem_write(`IFU_PC_INIT, INST_NEW0); // Stale copies stay in the cache.
    mem_write(`IFU_PC_INIT + 4, INST_NEW1);
    take_inst(1'b1, `IFU_PC_INIT, inst, pc);
    check_fetch(inst, pc, `IFU_PC_INIT + 8);
    start_reads = bus_reads;
    take_inst(1'b0, '0, inst, pc);
    check_fetch(inst, pc, `IFU_PC_INIT);
    take_inst(1'b0, '0, inst, pc);
    check_fetch(inst, pc, `IFU_PC_INIT + 4);
    check_reads(bus_reads - start_reads, 2);
    report_test("fence_invalidate", start_errors);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sequence and timeout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    rst          = 1'b1;
    ifu_rdata_i  = '0;
    ifu_rvalid_i = 1'b0;
    npc_i        = '0;
    pc_change_i  = 1'b0;
    pc_retire_i  = 1'b0;
    prev_valid_i = 1'b0;
    next_ready_i = 1'b0;
    rng_state    = 32'h07e441f1;
    mem_busy     = 1'b0;
    mem_wait     = 0;
    mem_addr     = '0;
    btb_model    = '0;
    bus_reads    = 0;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    sequential_fetch();
    cache_reuse();
    load_stall();
    branch_no_predict();
    speculation();
    fence_invalidate();
    $display("Summary: %0d tests passed, %0d failed, %0d errors", tests_passed,
             tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+common
common/ifu_pkg.sv
l1i_cache/l1i_cache.sv
design/ifu_fetch_ctrl.sv
design/ifu_top.sv
verif/tb_ifu.sv

// File: Bender.yml
package:
  name: ifu

sources:
  - include_dirs:
      - common
    files:
      - common/ifu_pkg.sv
      - l1i_cache/l1i_cache.sv
      - design/ifu_fetch_ctrl.sv
      - design/ifu_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verif/tb_ifu.sv
